// File: design/smc_access_seq.sv
`default_nettype none
`timescale 1ns/100ps

`include "smc_settings.svh"

module smc_access_seq (
  input  wire                             sys_clk17,
  input  wire                             n_sys_reset17,
  input  wire                             start,
  input  wire smc_size_pkg::smc_op_e      op,
  input  wire smc_size_pkg::xfer_size_e   xfer_size,
  input  wire smc_size_pkg::bus_size_e    bus_size,
  input  wire                             mem_ack,
  output logic                            mem_req,
  output logic                            mem_we,
  output logic                            busy,
  output logic                            done,
  output smc_size_pkg::smc_op_e           acc_op,
  output smc_size_pkg::xfer_size_e        acc_xfer,
  output smc_size_pkg::bus_size_e         acc_bus,
  output logic [`SMC_CNT_W-1:0]           acc_num,
  output logic                            piece_cap,
  output logic                            first_cap
);

  import smc_size_pkg::*;
  import smc_seq_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       take_req;      // start accepted this cycle
  logic       ack_low_seen;  // end of one four-phase access
  logic       first_pend;    // no piece captured yet

  //--------------------------------------------------
  // access count minus one, from the two sizes
  //--------------------------------------------------
  function automatic logic [`SMC_CNT_W-1:0] last_access(input xfer_size_e xs,
                                                        input bus_size_e  bs);
    logic [`SMC_CNT_W-1:0] cnt;
    cnt = '0;  // one access when bus is as wide or wider
    case (xs)
      xsiz_32:
      begin
        if (bs == bsiz_8)
          cnt = 2'd3;  // four bytes
        else if (bs == bsiz_16)
          cnt = 2'd1;  // two halfwords
      end
      xsiz_16:
      begin
        if (bs == bsiz_8)
          cnt = 2'd1;
      end
      default:
        cnt = '0;
    endcase
    return cnt;
  endfunction

  // status decodes of the state register
  assign mem_req      = (state_q == st_req);
  assign busy         = (state_q == st_req) || (state_q == st_wait_release);
  assign done         = (state_q == st_done);
  assign mem_we       = busy && (acc_op == op_write);  // held over whole access
  assign take_req     = start && !busy;
  assign ack_low_seen = (state_q == st_wait_release) && !mem_ack;
  assign piece_cap    = mem_req && mem_ack;
  assign first_cap    = piece_cap && first_pend;

  //--------------------------------------------------
  // next state
  //--------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle, st_done:
        state_d = take_req ? st_req : st_idle;  // back to back start allowed
      st_req:
      begin
        if (mem_ack)
          state_d = st_wait_release;
      end
      st_wait_release:
      begin
        if (!mem_ack)
          state_d = (acc_num == '0) ? st_done : st_req;
      end
      default:
        state_d = st_idle;
    endcase
  end

  always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
  begin
    if (!n_sys_reset17)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  //--------------------------------------------------
  // request store and access counter
  //--------------------------------------------------
  always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
  begin
    if (!n_sys_reset17)
    begin
      acc_op     <= op_read;
      acc_xfer   <= xsiz_8;
      acc_bus    <= bsiz_8;
      acc_num    <= '0;
      first_pend <= 1'b0;
    end
    else if (take_req)
    begin
      acc_op     <= op;
      acc_xfer   <= xfer_size;
      acc_bus    <= bus_size;
      acc_num    <= last_access(xfer_size, bus_size);
      first_pend <= 1'b1;
    end
    else
    begin
      if (piece_cap)
        first_pend <= 1'b0;
      if (ack_low_seen && (acc_num != '0))
        acc_num <= acc_num - 1'b1;  // next lane down
    end
  end

endmodule

`default_nettype wire

// File: design/smc_access_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "smc_settings.svh"

module smc_access_top (
  input  wire                            sys_clk17,
  input  wire                            n_sys_reset17,
  // host side
  input  wire                            start,
  input  wire smc_size_pkg::smc_op_e     op,
  input  wire smc_size_pkg::xfer_size_e  xfer_size,
  input  wire [`SMC_DATA_W-1:0]          wr_data,
  input  wire smc_size_pkg::bus_size_e   bus_size,
  output logic                           busy,
  output logic                           done,
  output logic [`SMC_DATA_W-1:0]         rd_data,
  // memory side, four-phase req/ack
  output logic                           mem_req,
  output logic                           mem_we,
  output logic [`SMC_DATA_W-1:0]         mem_wdata,
  input  wire                            mem_ack,
  input  wire [`SMC_DATA_W-1:0]          mem_rdata
);

  import smc_size_pkg::*;

  xfer_size_e            acc_xfer;   // stored request sizes
  bus_size_e             acc_bus;
  logic [`SMC_CNT_W-1:0] acc_num;    // lane of the current access
  logic                  piece_cap;
  logic                  first_cap;

  //--------------------------------------------------
  // sequencer, owns the handshake
  //--------------------------------------------------
  smc_access_seq u_seq (
    .sys_clk17     (sys_clk17),
    .n_sys_reset17 (n_sys_reset17),
    .start         (start),
    .op            (op),
    .xfer_size     (xfer_size),
    .bus_size      (bus_size),
    .mem_ack       (mem_ack),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .busy          (busy),
    .done          (done),
    .acc_op        (),  // stored op only feeds mem_we inside the sequencer
    .acc_xfer      (acc_xfer),
    .acc_bus       (acc_bus),
    .acc_num       (acc_num),
    .piece_cap     (piece_cap),
    .first_cap     (first_cap)
  );

  // write path
  smc_wdata_steer u_steer (
    .wr_data   (wr_data),
    .acc_bus   (acc_bus),
    .acc_num   (acc_num),
    .mem_wdata (mem_wdata)
  );

  // read path
  smc_rdata_pack u_pack (
    .sys_clk17     (sys_clk17),
    .n_sys_reset17 (n_sys_reset17),
    .mem_rdata     (mem_rdata),
    .piece_cap     (piece_cap),
    .first_cap     (first_cap),
    .acc_num       (acc_num),
    .acc_bus       (acc_bus),
    .acc_xfer      (acc_xfer),
    .rd_data       (rd_data)
  );

endmodule

`default_nettype wire

// File: design/smc_rdata_pack.sv
`default_nettype none
`timescale 1ns/100ps

`include "smc_settings.svh"

module smc_rdata_pack (
  input  wire                            sys_clk17,
  input  wire                            n_sys_reset17,
  input  wire [`SMC_DATA_W-1:0]          mem_rdata,
  input  wire                            piece_cap,
  input  wire                            first_cap,
  input  wire [`SMC_CNT_W-1:0]           acc_num,
  input  wire smc_size_pkg::bus_size_e   acc_bus,
  input  wire smc_size_pkg::xfer_size_e  acc_xfer,
  output logic [`SMC_DATA_W-1:0]         rd_data
);

  import smc_size_pkg::*;

  // byte lanes of the gathered word, lane 0 is least significant
  logic [`SMC_MAX_ACCESSES-1:0][`SMC_BYTE_W-1:0] store_q;
  logic [`SMC_MAX_ACCESSES-1:0][`SMC_BYTE_W-1:0] store_d;

  //--------------------------------------------------
  // merge the incoming piece into its lane
  //--------------------------------------------------
  always_comb
  begin
    // a new transfer starts from an empty word
    store_d = first_cap ? '0 : store_q;
    case (acc_bus)
      bsiz_8:
        store_d[acc_num] = mem_rdata[`SMC_BYTE_W-1:0];
      bsiz_16:
      begin
        // halfword lane acc_num[0] covers two byte lanes
        store_d[{acc_num[0], 1'b1}] = mem_rdata[2*`SMC_BYTE_W-1:`SMC_BYTE_W];
        store_d[{acc_num[0], 1'b0}] = mem_rdata[`SMC_BYTE_W-1:0];
      end
      bsiz_32:
        store_d = mem_rdata;  // whole word in one go
      default:
        store_d = store_q;
    endcase
  end

  // written at the end of the ack cycle, ready well before done
  always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
  begin
    if (!n_sys_reset17)
      store_q <= '0;
    else if (piece_cap)
      store_q <= store_d;
  end

  //--------------------------------------------------
  // host word, narrow results repeated to 32 bits
  //--------------------------------------------------
  always_comb
  begin
    case (acc_xfer)
      xsiz_8:
        rd_data = {`SMC_MAX_ACCESSES{store_q[0]}};  // byte in all four lanes
      xsiz_16:
        rd_data = {2{store_q[1], store_q[0]}};  // low halfword twice
      xsiz_32:
        rd_data = store_q;
      default:
        rd_data = store_q;
    endcase
  end

endmodule

`default_nettype wire

// File: design/smc_seq_pkg.sv
`default_nettype none

// sequencing types for the access unit
package smc_seq_pkg;

  // one pass of st_req and st_wait_release per memory access
  typedef enum logic [1:0] {
    st_idle         = 2'd0,  // waiting for start
    st_req          = 2'd1,  // req high, waiting for ack
    st_wait_release = 2'd2,  // req low, waiting for ack to drop
    st_done         = 2'd3   // single cycle, done pulse
  } seq_state_e;

endpackage

`default_nettype wire

// File: design/smc_settings.svh
`ifndef SMC_SETTINGS_SVH
`define SMC_SETTINGS_SVH

// host word, one whole transfer at most
`define SMC_DATA_W 32

// one memory lane, the narrowest bus
`define SMC_BYTE_W 8

// remaining-access counter, counts 3 down to 0
`define SMC_CNT_W 2

// worst case is a 32 bit transfer on an 8 bit bus
`define SMC_MAX_ACCESSES 4

`endif

// File: design/smc_size_pkg.sv
`default_nettype none

// data sizes seen by the access unit
package smc_size_pkg;

  //--------------------------------------------------
  // host transfer size
  //--------------------------------------------------
  typedef enum logic [1:0] {
    xsiz_8  = 2'd0,  // byte
    xsiz_16 = 2'd1,  // halfword
    xsiz_32 = 2'd2   // word
  } xfer_size_e;

  //--------------------------------------------------
  // external memory width
  //--------------------------------------------------
  typedef enum logic [1:0] {
    bsiz_8  = 2'd0,  // 8 bit device
    bsiz_16 = 2'd1,  // 16 bit device
    bsiz_32 = 2'd2   // full width device
  } bus_size_e;

  // host operation
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } smc_op_e;

endpackage

`default_nettype wire

// File: design/smc_wdata_steer.sv
`default_nettype none
`timescale 1ns/100ps

`include "smc_settings.svh"

module smc_wdata_steer (
  input  wire [`SMC_DATA_W-1:0]         wr_data,
  input  wire smc_size_pkg::bus_size_e  acc_bus,
  input  wire [`SMC_CNT_W-1:0]          acc_num,
  output logic [`SMC_DATA_W-1:0]        mem_wdata
);

  import smc_size_pkg::*;

  localparam int HALF_W = 2 * `SMC_BYTE_W;

  //--------------------------------------------------
  // lane select
  // counter runs down so the high lane goes out first
  //--------------------------------------------------
  always_comb
  begin
    mem_wdata = '0;  // unused upper bits stay zero
    case (acc_bus)
      bsiz_8:
      begin
        // byte acc_num of the host word
        mem_wdata[`SMC_BYTE_W-1:0] = wr_data[acc_num * `SMC_BYTE_W +: `SMC_BYTE_W];
      end
      bsiz_16:
      begin
        // only two halfword lanes, bit 0 of the count picks one
        mem_wdata[HALF_W-1:0] = wr_data[acc_num[0] * HALF_W +: HALF_W];
      end
      bsiz_32:
        mem_wdata = wr_data;  // full width, single access
      default:
        mem_wdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: dv/tb_smc_vectors.svh
`ifndef TB_SMC_VECTORS_SVH
`define TB_SMC_VECTORS_SVH

// one host transfer and what it should produce
typedef struct packed {
  smc_op_e                                     op;
  xfer_size_e                                  xfer;
  bus_size_e                                   bus;
  logic [`SMC_DATA_W-1:0]                      wr_data;
  logic [0:`SMC_MAX_ACCESSES-1][`SMC_DATA_W-1:0] rd_piece;  // memory answers, access order
  int                                          n_acc;     // req rises before done
  logic [0:`SMC_MAX_ACCESSES-1][`SMC_DATA_W-1:0] wr_piece;  // mem_wdata, access order
  logic [`SMC_DATA_W-1:0]                      rd_word;   // rd_data after done
} vec_row_t;

localparam int N_ROWS = 15;

vec_row_t vectors [0:N_ROWS-1];

task automatic load_vectors();
  // --------------------------------------------------
  // writes, high lane first, zero above the lane
  // --------------------------------------------------
  vectors[0]  = '{op_write, xsiz_32, bsiz_8, 32'h1122_3344, '0, 4,
                  {32'h0000_0011, 32'h0000_0022, 32'h0000_0033, 32'h0000_0044}, '0};
  vectors[1]  = '{op_write, xsiz_32, bsiz_16, 32'hCAFE_F00D, '0, 2,
                  {32'h0000_CAFE, 32'h0000_F00D, 64'h0}, '0};
  vectors[2]  = '{op_write, xsiz_32, bsiz_32, 32'hDEAD_BEEF, '0, 1,
                  {32'hDEAD_BEEF, 96'h0}, '0};
  vectors[3]  = '{op_write, xsiz_16, bsiz_8, 32'h5566_A1B2, '0, 2,
                  {32'h0000_00A1, 32'h0000_00B2, 64'h0}, '0};
  vectors[4]  = '{op_write, xsiz_16, bsiz_16, 32'h9988_7766, '0, 1,
                  {32'h0000_7766, 96'h0}, '0};
  vectors[5]  = '{op_write, xsiz_8, bsiz_32, 32'h1234_56A5, '0, 1,
                  {32'h1234_56A5, 96'h0}, '0};  // full bus, word as is
  vectors[6]  = '{op_write, xsiz_8, bsiz_8, 32'hFFFF_FF3C, '0, 1,
                  {32'h0000_003C, 96'h0}, '0};
  // --------------------------------------------------
  // reads, junk above the bus width on purpose
  // --------------------------------------------------
  vectors[7]  = '{op_read, xsiz_32, bsiz_8, 32'h0,
                  {32'hEEEE_EE12, 32'hEEEE_EE34, 32'hEEEE_EE56, 32'hEEEE_EE78}, 4,
                  '0, 32'h1234_5678};
  vectors[8]  = '{op_read, xsiz_32, bsiz_16, 32'h0,
                  {32'hFFFF_ABCD, 32'h5555_0123, 64'h0}, 2, '0, 32'hABCD_0123};
  vectors[9]  = '{op_read, xsiz_32, bsiz_32, 32'h0,
                  {32'h89AB_CDEF, 96'h0}, 1, '0, 32'h89AB_CDEF};
  vectors[10] = '{op_read, xsiz_16, bsiz_8, 32'h0,
                  {32'h7777_77C3, 32'h7777_775A, 64'h0}, 2, '0, 32'hC35A_C35A};
  vectors[11] = '{op_read, xsiz_16, bsiz_32, 32'h0,
                  {32'hA5A5_BEEF, 96'h0}, 1, '0, 32'hBEEF_BEEF};  // low half of wide bus
  vectors[12] = '{op_read, xsiz_8, bsiz_16, 32'h0,
                  {32'h0000_33C9, 96'h0}, 1, '0, 32'hC9C9_C9C9};
  vectors[13] = '{op_read, xsiz_8, bsiz_8, 32'h0,
                  {32'hFFFF_FF7F, 96'h0}, 1, '0, 32'h7F7F_7F7F};
  vectors[14] = '{op_read, xsiz_16, bsiz_16, 32'h0,
                  {32'h1234_5678, 96'h0}, 1, '0, 32'h5678_5678};
endtask

`endif

// File: dv/tb_smc_access.sv
`default_nettype none
`timescale 1ns/100ps

`include "smc_settings.svh"

module tb_smc_access;

  import smc_size_pkg::*;
  import smc_seq_pkg::*;

  `include "tb_smc_vectors.svh"

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int WATCHDOG_CYCLES = N_ROWS * `SMC_MAX_ACCESSES * 10 + 2 * RESET_CYCLES;

  logic                   sys_clk17;
  logic                   n_sys_reset17;
  logic                   start;
  smc_op_e                op;
  xfer_size_e             xfer_size;
  logic [`SMC_DATA_W-1:0] wr_data;
  bus_size_e              bus_size;
  logic                   busy;
  logic                   done;
  logic [`SMC_DATA_W-1:0] rd_data;
  logic                   mem_req;
  logic                   mem_we;
  logic [`SMC_DATA_W-1:0] mem_wdata;
  logic                   mem_ack;
  logic [`SMC_DATA_W-1:0] mem_rdata;

  int         seed = 83820;
  int         error_cnt = 0;
  int         cyc = 0;          // rising edges since time zero
  int         cur_row = 0;      // row the memory model serves
  int         access_cnt = 0;   // req rises in this transfer
  int         ack_low_cyc = 0;  // edge where the DUT sees the last ack low
  int         done_pulses = 0;
  logic [7:0] piece_bytes [$];  // write pieces, high byte first

  smc_access_top u_dut (
    .sys_clk17     (sys_clk17),
    .n_sys_reset17 (n_sys_reset17),
    .start         (start),
    .op            (op),
    .xfer_size     (xfer_size),
    .wr_data       (wr_data),
    .bus_size      (bus_size),
    .busy          (busy),
    .done          (done),
    .rd_data       (rd_data),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  initial
  begin
    sys_clk17 = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk17 = ~sys_clk17;
  end

  always @(posedge sys_clk17)
  begin
    cyc <= cyc + 1;
    if (done)
      done_pulses <= done_pulses + 1;  // every pulse, not just expected ones
  end

  // --------------------------------------------------
  // error exits
  // --------------------------------------------------
  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_in_words(input string msg);
    error_cnt++;
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_piece(input string name, input logic [`SMC_DATA_W-1:0] got,
                             input logic [`SMC_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rdata(input string name, input logic [`SMC_DATA_W-1:0] got,
                             input logic [`SMC_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_size(input string name, input xfer_size_e got, input xfer_size_e exp);
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // we and wdata must not move until ack falls
  task automatic bus_held_stable(input logic we_seen, input logic [`SMC_DATA_W-1:0] wd_seen);
    check_flag("mem_we", mem_we, we_seen);
    check_piece("mem_wdata", mem_wdata, wd_seen);
  endtask

  // --------------------------------------------------
  // memory model, four-phase slave with random delay
  // --------------------------------------------------
  initial
  begin : mem_model
    vec_row_t               row;
    logic                   we_seen;
    logic [`SMC_DATA_W-1:0] wd_seen;
    int                     idx;
    int                     delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge sys_clk17);
      if (mem_req && !mem_ack)  // new access
      begin
        row     = vectors[cur_row];
        we_seen = mem_we;
        wd_seen = mem_wdata;
        if (access_cnt >= `SMC_MAX_ACCESSES)
          fail_in_words("memory saw more accesses than any transfer can need");
        check_flag("mem_we", we_seen, row.op == op_write);
        if (we_seen)
        begin
          piece_bytes.push_back(wd_seen[31:24]);
          piece_bytes.push_back(wd_seen[23:16]);
          piece_bytes.push_back(wd_seen[15:8]);
          piece_bytes.push_back(wd_seen[7:0]);
        end
        idx = access_cnt;
        access_cnt++;
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(posedge sys_clk17);
          if (!mem_req)
            fail_in_words("mem_req fell before mem_ack was raised");
          bus_held_stable(we_seen, wd_seen);
        end
        mem_ack   <= 1'b1;
        mem_rdata <= (row.op == op_read) ? row.rd_piece[idx] : '0;
        do
        begin
          @(posedge sys_clk17);
          bus_held_stable(we_seen, wd_seen);
        end
        while (mem_req);
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(posedge sys_clk17);
          if (mem_req)
            fail_in_words("mem_req rose again while mem_ack was still high");
          bus_held_stable(we_seen, wd_seen);
        end
        mem_ack     <= 1'b0;
        mem_rdata   <= 32'hBAD0_BAD0;  // not valid with ack low
        ack_low_cyc = cyc + 1;
      end
    end
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial
  begin : watchdog
    seq_state_e st;
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    st = u_dut.u_seq.state_q;
    $display("run timed out after %0d ns, sequencer in state %s",
             WATCHDOG_CYCLES * CLK_PERIOD, st.name());
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // main sequence over the table
  // --------------------------------------------------
  initial
  begin : main_seq
    vec_row_t               row;
    logic [`SMC_DATA_W-1:0] got_piece;
    int                     i;
    int                     k;
    start         = 1'b0;
    op            = op_read;
    xfer_size     = xsiz_8;
    wr_data       = '0;
    bus_size      = bsiz_8;
    n_sys_reset17 = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge sys_clk17);
    n_sys_reset17 <= 1'b1;
    @(posedge sys_clk17);
    check_flag("mem_req", mem_req, 1'b0);  // quiet after reset
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_rdata("rd_data", rd_data, '0);

    for (i = 0; i < N_ROWS; i++)
    begin
      row        = vectors[i];
      cur_row    = i;
      access_cnt = 0;
      piece_bytes.delete();
      @(posedge sys_clk17);
      op        <= row.op;
      xfer_size <= row.xfer;
      bus_size  <= row.bus;
      wr_data   <= row.wr_data;
      start     <= 1'b1;
      @(posedge sys_clk17);
      start <= 1'b0;
      @(posedge sys_clk17);
      check_flag("mem_req", mem_req, 1'b1);  // req one cycle after start
      check_size("acc_xfer", u_dut.acc_xfer, row.xfer);
      do
      begin
        check_flag("busy", busy, 1'b1);  // high until the done cycle
        @(posedge sys_clk17);
      end
      while (!done);
      // done sampled one edge after the DUT saw the last ack low
      check_flag("busy", busy, 1'b0);
      check_count("done cycle", cyc, ack_low_cyc + 1);
      check_count("access count", access_cnt, row.n_acc);
      if (row.op == op_write)
      begin
        check_count("write piece bytes", piece_bytes.size(), 4 * row.n_acc);
        for (k = 0; k < row.n_acc; k++)
        begin
          got_piece = {piece_bytes[4*k], piece_bytes[4*k+1],
                       piece_bytes[4*k+2], piece_bytes[4*k+3]};
          check_piece("mem_wdata", got_piece, row.wr_piece[k]);
        end
      end
      else
      begin
        check_count("write piece bytes", piece_bytes.size(), 0);
        check_rdata("rd_data", rd_data, row.rd_word);
      end
      @(posedge sys_clk17);
      check_flag("done", done, 1'b0);  // single pulse
      check_count("done pulses", done_pulses, i + 1);
      if (row.op == op_read)
        check_rdata("rd_data", rd_data, row.rd_word);  // held until next start
    end

    if (error_cnt == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
+incdir+dv
design/smc_size_pkg.sv
design/smc_seq_pkg.sv
design/smc_access_seq.sv
design/smc_wdata_steer.sv
design/smc_rdata_pack.sv
design/smc_access_top.sv
dv/tb_smc_access.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the access unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_smc_access
LOG=sim.log

if ! verilator --binary --timing -f list.f --top-module "$TOP" \
    --Mdir "$BUILD_DIR" -o "$TOP"; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0
